// File: Makefile
# Verilator build, run, lint and clean for the bounding box stage

TOP := bbox_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert --timing -sv -Wno-fatal -f sources.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TESTS FAILED" sim.log; then exit 1; fi
	@grep -q "TESTS PASSED" sim.log

lint:
	verilator --lint-only --timing -sv -Wall -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: design/bbox_clip.sv
// Combinational back of the bounding box stage, snaps the box to the sample grid and clips it
`timescale 1ns/10ps

module bbox_clip import geometry_pkg::*, msaa_pkg::*; #(
    parameter int SIGFIG = 24,
    parameter int RADIX  = 10
) (
    input  logic signed [SIGFIG-1:0] box_raw [CORNER_UR:CORNER_LL][AXIS_Y:AXIS_X],
    input  logic                     backface,
    input  logic                     valid_in,
    input  logic signed [SIGFIG-1:0] screen [AXIS_Y:AXIS_X],
    input  subsample_e               subsample,
    output logic signed [SIGFIG-1:0] box_clip [CORNER_UR:CORNER_LL][AXIS_Y:AXIS_X],
    output logic                     valid_clip
);

    // Integer bits above the binary point
    localparam int INT_BITS = SIGFIG - RADIX;

    typedef logic signed [SIGFIG-1:0] coord_t;

    // Fraction bits that survive for the current code
    int unsigned      kept;
    // Ones on the kept fraction bits only
    logic [RADIX-1:0] frac_mask;
    // Whole coordinate mask, integer part always kept
    coord_t           grid_mask;
    // Corners after the floor, before the screen clamp
    coord_t           snapped [CORNER_UR:CORNER_LL][AXIS_Y:AXIS_X];
    // Raw box touches the screen on both axes
    logic             on_screen;

    // Build the floor mask from the MSAA code
    always_comb begin
        kept      = keep_frac_bits(subsample);
        // Shift ones down by the kept count, then invert to mark the top bits
        frac_mask = ~({RADIX{1'b1}} >> kept);
        grid_mask = {{INT_BITS{1'b1}}, frac_mask};
    end

    // Floor then clamp every corner
    always_comb begin
        for (int a = AXIS_X; a <= AXIS_Y; a++) begin
            // Clearing low bits of a two's complement value rounds toward minus infinity
            snapped[CORNER_LL][a] = box_raw[CORNER_LL][a] & grid_mask;
            snapped[CORNER_UR][a] = box_raw[CORNER_UR][a] & grid_mask;

            // Lower left never sits left of or below the origin
            if (snapped[CORNER_LL][a] < 0) begin
                box_clip[CORNER_LL][a] = '0;
            end else begin
                box_clip[CORNER_LL][a] = snapped[CORNER_LL][a];
            end

            // Upper right never passes the screen edge
            if (snapped[CORNER_UR][a] > screen[a]) begin
                box_clip[CORNER_UR][a] = screen[a];
            end else begin
                box_clip[CORNER_UR][a] = snapped[CORNER_UR][a];
            end
        end
    end

    // Overlap test on the unsnapped box
    always_comb begin
        on_screen = 1'b1;
        for (int a = AXIS_X; a <= AXIS_Y; a++) begin
            // Box starting past the far edge sees nothing
            if (box_raw[CORNER_LL][a] > screen[a]) begin
                on_screen = 1'b0;
            end
            // Box ending before the origin sees nothing either
            if (box_raw[CORNER_UR][a] < 0) begin
                on_screen = 1'b0;
            end
        end
    end

    // Keep only real, front-facing, visible triangles
    assign valid_clip = valid_in && !backface && on_screen;

endmodule

// File: design/bbox_extent.sv
// Combinational front of the bounding box stage, finds the raw x,y extent and the back-face flag
`timescale 1ns/10ps

module bbox_extent import geometry_pkg::*; #(
    parameter int SIGFIG = 24
) (
    input  logic signed [SIGFIG-1:0] tri_in [VERTS-1:0][AXES-1:0],
    output logic signed [SIGFIG-1:0] box_raw [CORNER_UR:CORNER_LL][AXIS_Y:AXIS_X],
    output logic                     backface
);

    // Coordinate as it arrives
    typedef logic signed [SIGFIG-1:0] coord_t;
    // One extra bit so an edge difference never wraps
    typedef logic signed [SIGFIG:0] delta_t;
    // Full width product of two edge differences
    typedef logic signed [2*SIGFIG+1:0] cross_t;

    // Pairwise less-than results, one bit per axis
    logic [AXIS_Y:AXIS_X] lt01;
    logic [AXIS_Y:AXIS_X] lt02;
    logic [AXIS_Y:AXIS_X] lt12;

    // Edge differences for the winding test
    delta_t dx01;
    delta_t dy01;
    delta_t dx12;
    delta_t dy12;
    cross_t cross_lhs;
    cross_t cross_rhs;

    // Min and max per axis from three compares
    always_comb begin
        for (int a = AXIS_X; a <= AXIS_Y; a++) begin
            lt01[a] = tri_in[0][a] < tri_in[1][a];
            lt02[a] = tri_in[0][a] < tri_in[2][a];
            lt12[a] = tri_in[1][a] < tri_in[2][a];

            // Smallest of the three goes to the lower left corner
            if (lt01[a]) begin
                box_raw[CORNER_LL][a] = lt02[a] ? tri_in[0][a] : tri_in[2][a];
            end else begin
                box_raw[CORNER_LL][a] = lt12[a] ? tri_in[1][a] : tri_in[2][a];
            end

            // Largest goes to the upper right corner
            if (lt01[a]) begin
                box_raw[CORNER_UR][a] = lt12[a] ? tri_in[2][a] : tri_in[1][a];
            end else begin
                box_raw[CORNER_UR][a] = lt02[a] ? tri_in[2][a] : tri_in[0][a];
            end
        end
    end

    // Edge 0 to 1 and edge 1 to 2, widened before subtracting
    assign dx01 = delta_t'(coord_t'(tri_in[1][AXIS_X])) - delta_t'(coord_t'(tri_in[0][AXIS_X]));
    assign dy01 = delta_t'(coord_t'(tri_in[1][AXIS_Y])) - delta_t'(coord_t'(tri_in[0][AXIS_Y]));
    assign dx12 = delta_t'(coord_t'(tri_in[2][AXIS_X])) - delta_t'(coord_t'(tri_in[1][AXIS_X]));
    assign dy12 = delta_t'(coord_t'(tri_in[2][AXIS_Y])) - delta_t'(coord_t'(tri_in[1][AXIS_Y]));

    // Both halves of the cross product in full precision
    assign cross_lhs = cross_t'(dx01) * cross_t'(dy12);
    assign cross_rhs = cross_t'(dx12) * cross_t'(dy01);

    // Culled winding when (x1-x0)(y2-y1) exceeds (x2-x1)(y1-y0)
    assign backface = cross_lhs > cross_rhs;

endmodule

// File: design/bbox_top.sv
// Top of the rasterizer bounding box stage, joins extent, clip and the four delay pipes
`timescale 1ns/10ps

module bbox_top import geometry_pkg::*, msaa_pkg::*; #(
    parameter int SIGFIG     = 24,
    parameter int RADIX      = 10,
    parameter int PIPE_DEPTH = 3
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic signed [SIGFIG-1:0] tri_in [VERTS-1:0][AXES-1:0],
    input  logic        [SIGFIG-1:0] color_in [COLORS-1:0],
    input  logic                     valid_in,
    input  logic                     halt,
    input  logic signed [SIGFIG-1:0] screen [AXIS_Y:AXIS_X],
    input  subsample_e               subsample,
    output logic signed [SIGFIG-1:0] tri_out [VERTS-1:0][AXES-1:0],
    output logic        [SIGFIG-1:0] color_out [COLORS-1:0],
    output logic signed [SIGFIG-1:0] box_out [CORNER_UR:CORNER_LL][AXIS_Y:AXIS_X],
    output logic                     valid_out
);

    // Payload shapes carried by the pipes
    typedef logic signed [SIGFIG-1:0] coord_t;
    typedef logic        [SIGFIG-1:0] color_t;
    typedef coord_t tri_t [VERTS-1:0][AXES-1:0];
    typedef color_t color_arr_t [COLORS-1:0];
    typedef coord_t box_t [CORNER_UR:CORNER_LL][AXIS_Y:AXIS_X];

    // Extent to clip, same cycle
    box_t box_raw;
    logic backface;

    // Clip to the box and valid pipes
    box_t box_clip;
    logic valid_clip;

    bbox_extent #(
        .SIGFIG (SIGFIG)
    ) bbox_extent_i (
        .tri_in   (tri_in),
        .box_raw  (box_raw),
        .backface (backface)
    );

    bbox_clip #(
        .SIGFIG (SIGFIG),
        .RADIX  (RADIX)
    ) bbox_clip_i (
        .box_raw    (box_raw),
        .backface   (backface),
        .valid_in   (valid_in),
        .screen     (screen),
        .subsample  (subsample),
        .box_clip   (box_clip),
        .valid_clip (valid_clip)
    );

    // Triangle rides alongside its box
    stage_pipe #(
        .payload_t  (tri_t),
        .PIPE_DEPTH (PIPE_DEPTH)
    ) tri_pipe_i (
        .clk   (clk),
        .rst_n (rst_n),
        .halt  (halt),
        .d     (tri_in),
        .q     (tri_out)
    );

    stage_pipe #(
        .payload_t  (color_arr_t),
        .PIPE_DEPTH (PIPE_DEPTH)
    ) color_pipe_i (
        .clk   (clk),
        .rst_n (rst_n),
        .halt  (halt),
        .d     (color_in),
        .q     (color_out)
    );

    stage_pipe #(
        .payload_t  (box_t),
        .PIPE_DEPTH (PIPE_DEPTH)
    ) box_pipe_i (
        .clk   (clk),
        .rst_n (rst_n),
        .halt  (halt),
        .d     (box_clip),
        .q     (box_out)
    );

    // Valid uses the same chain with a one-bit payload
    stage_pipe #(
        .payload_t  (logic),
        .PIPE_DEPTH (PIPE_DEPTH)
    ) valid_pipe_i (
        .clk   (clk),
        .rst_n (rst_n),
        .halt  (halt),
        .d     (valid_clip),
        .q     (valid_out)
    );

endmodule

// File: design/geometry_pkg.sv
// Index and size constants for triangle vertices, axes, box corners and colors, shared by the RTL
package geometry_pkg;

    // Vertices in one triangle
    localparam int VERTS = 3;

    // Axes carried per vertex, x y and z
    localparam int AXES = 3;

    // Axis positions inside a vertex
    // z sits at index 2 and only travels with the triangle
    localparam int AXIS_X = 0;
    localparam int AXIS_Y = 1;

    // Corner positions inside a bounding box
    // Lower left holds the minima, upper right the maxima
    localparam int CORNER_LL = 0;
    localparam int CORNER_UR = 1;

    // Color channels per triangle
    localparam int COLORS = 3;

endpackage

// File: design/msaa_pkg.sv
// MSAA subsample code and its mapping to surviving fraction bits, used by the clip stage and top
package msaa_pkg;

    // One-hot code, the set bit moves down as the sample grid gets finer
    // 1x is one sample per pixel, 64x is an eighth of a pixel on a side
    typedef enum logic [3:0] {
        SS_1X  = 4'b1000,
        SS_4X  = 4'b0100,
        SS_16X = 4'b0010,
        SS_64X = 4'b0001
    } subsample_e;

    // Number of top fraction bits kept when flooring to the sample grid
    // Each step to a finer grid halves the sample pitch, so one more bit survives
    function automatic int unsigned keep_frac_bits(input subsample_e code);
        int unsigned bits;
        case (code)
            SS_1X:   bits = 0;
            SS_4X:   bits = 1;
            SS_16X:  bits = 2;
            SS_64X:  bits = 3;
            // Illegal codes fall back to whole pixels
            default: bits = 0;
        endcase
        return bits;
    endfunction

endpackage

// File: design/stage_pipe.sv
// Halt-enabled register chain used once per payload to delay the bounding box stage outputs
`timescale 1ns/10ps

module stage_pipe #(
    parameter type payload_t  = logic,
    parameter int  PIPE_DEPTH = 3
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     halt,
    input  payload_t d,
    output payload_t q
);

    // Stage 0 takes the input, the last stage drives q
    payload_t stage [0:PIPE_DEPTH-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Every leaf of every stage goes to zero
            stage <= '{default: '0};
        end else if (!halt) begin
            stage[0] <= d;
            // Advance the rest of the chain by one
            for (int i = 1; i < PIPE_DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
        // Halt high leaves the whole chain as it is
    end

    assign q = stage[PIPE_DEPTH-1];

endmodule

// File: sources.f
design/geometry_pkg.sv
design/msaa_pkg.sv
design/bbox_extent.sv
design/bbox_clip.sv
design/stage_pipe.sv
design/bbox_top.sv
verif/bbox_assert.sv
verif/bbox_tb.sv

// File: verif/bbox_assert.sv
// Bound checker for the bounding box stage ports, covers reset, box order, screen range and halt hold
`timescale 1ns/10ps

module bbox_assert import geometry_pkg::*; #(
    parameter int SIGFIG = 24
) (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     halt,
    input logic                     valid_out,
    input logic signed [SIGFIG-1:0] screen [AXIS_Y:AXIS_X],
    input logic signed [SIGFIG-1:0] box_out [CORNER_UR:CORNER_LL][AXIS_Y:AXIS_X],
    input logic signed [SIGFIG-1:0] tri_out [VERTS-1:0][AXES-1:0],
    input logic        [SIGFIG-1:0] color_out [COLORS-1:0]
);

    // Box corners, colors and triangle words, plus the valid bit
    localparam int WORDS = 4 + COLORS + VERTS * AXES;

    // Failure count, summed into the testbench verdict
    int fails = 0;

    // Every output in one vector for the hold check
    logic [WORDS*SIGFIG:0] out_flat;

    always_comb begin
        out_flat    = '0;
        out_flat[0] = valid_out;
        for (int c = 0; c < 2; c++) begin
            for (int a = 0; a < 2; a++) begin
                out_flat[1 + (c * 2 + a) * SIGFIG +: SIGFIG] = box_out[c][a];
            end
        end
        for (int c = 0; c < COLORS; c++) begin
            out_flat[1 + (4 + c) * SIGFIG +: SIGFIG] = color_out[c];
        end
        for (int v = 0; v < VERTS; v++) begin
            for (int a = 0; a < AXES; a++) begin
                out_flat[1 + (4 + COLORS + v * AXES + a) * SIGFIG +: SIGFIG] = tri_out[v][a];
            end
        end
    end

    // Cleared chain never claims a triangle
    reset_quiet: assert property (@(posedge clk) !rst_n |-> !valid_out)
        else begin
            fails++;
            $error("valid_out high while reset is asserted");
        end

    // Snapped and clamped corners keep their order
    box_ordered: assert property (@(posedge clk) disable iff (!rst_n)
        valid_out |-> box_out[CORNER_LL][AXIS_X] <= box_out[CORNER_UR][AXIS_X]
                   && box_out[CORNER_LL][AXIS_Y] <= box_out[CORNER_UR][AXIS_Y])
        else begin
            fails++;
            $error("valid box has lower left past upper right");
        end

    // All four corner coordinates inside the screen
    box_on_screen: assert property (@(posedge clk) disable iff (!rst_n)
        valid_out |-> box_out[CORNER_LL][AXIS_X] >= 0 && box_out[CORNER_LL][AXIS_Y] >= 0
                   && box_out[CORNER_UR][AXIS_X] <= screen[AXIS_X]
                   && box_out[CORNER_UR][AXIS_Y] <= screen[AXIS_Y])
        else begin
            fails++;
            $error("valid box lies outside zero and screen");
        end

    // Halt at the last edge means nothing moved
    halt_holds: assert property (@(posedge clk) disable iff (!rst_n)
        $past(halt) |-> $stable(out_flat))
        else begin
            fails++;
            $error("outputs changed across an edge with halt high");
        end

endmodule

// File: verif/bbox_tb.sv
// Testbench for the bounding box stage, drives directed and random triangles against a box model
`timescale 1ns/10ps

module bbox_tb import geometry_pkg::*, msaa_pkg::*; ();

    localparam int SIGFIG     = 24;
    localparam int RADIX      = 10;
    localparam int PIPE_DEPTH = 3;
    // Grid, clamp, reject, hold and random budgets, then reset
    localparam int TEST_CYCLES = 4 * (PIPE_DEPTH + 2) + (PIPE_DEPTH + 2) + (PIPE_DEPTH + 4)
                               + (PIPE_DEPTH + 10) + (400 + PIPE_DEPTH + 1) + 10;
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES + 100;

    // What one accepted input should produce at the far end
    typedef struct packed {
        logic signed [SIGFIG-1:0]                   ll_x;
        logic signed [SIGFIG-1:0]                   ll_y;
        logic signed [SIGFIG-1:0]                   ur_x;
        logic signed [SIGFIG-1:0]                   ur_y;
        logic                                       valid;
        logic [VERTS-1:0][AXES-1:0][SIGFIG-1:0]     tri_v;
        logic [COLORS-1:0][SIGFIG-1:0]              color;
    } expect_t;

    logic                     clk;
    logic                     rst_n;
    logic signed [SIGFIG-1:0] tri_in [VERTS-1:0][AXES-1:0];
    logic        [SIGFIG-1:0] color_in [COLORS-1:0];
    logic                     valid_in;
    logic                     halt;
    logic signed [SIGFIG-1:0] screen [AXIS_Y:AXIS_X];
    subsample_e               subsample;
    logic signed [SIGFIG-1:0] tri_out [VERTS-1:0][AXES-1:0];
    logic        [SIGFIG-1:0] color_out [COLORS-1:0];
    logic signed [SIGFIG-1:0] box_out [CORNER_UR:CORNER_LL][AXIS_Y:AXIS_X];
    logic                     valid_out;

    // Staged inputs, moved onto the bus at the falling edge
    logic signed [SIGFIG-1:0] tri_next [VERTS-1:0][AXES-1:0];
    subsample_e               sub_next;
    expect_t                  exp_q [$];
    int                       errors = 0;
    int                       checks = 0;
    int                       serial = 0;
    int                       cycles = 0;
    int                       seed;

    bbox_top #(
        .SIGFIG     (SIGFIG),
        .RADIX      (RADIX),
        .PIPE_DEPTH (PIPE_DEPTH)
    ) bbox_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .tri_in    (tri_in),
        .color_in  (color_in),
        .valid_in  (valid_in),
        .halt      (halt),
        .screen    (screen),
        .subsample (subsample),
        .tri_out   (tri_out),
        .color_out (color_out),
        .box_out   (box_out),
        .valid_out (valid_out)
    );

    bind bbox_top bbox_assert #(.SIGFIG(SIGFIG)) bbox_assert_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .halt      (halt),
        .valid_out (valid_out),
        .screen    (screen),
        .box_out   (box_out),
        .tri_out   (tri_out),
        .color_out (color_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Hard stop if the directed and random tests overrun
    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic longint fixed(input int whole, input int frac);
        return (longint'(whole) <<< RADIX) + frac;
    endfunction

    // Roughly 1200 pixels either side of the origin
    function automatic longint rand_coord();
        return $random(seed) % (1200 <<< RADIX);
    endfunction

    // Box, valid, triangle and colors from the stage rules, applied to the bus as it stands
    function automatic expect_t model_box();
        expect_t e;
        longint  pt [2][VERTS];
        longint  lo [2];
        longint  hi [2];
        longint  lhs;
        longint  rhs;
        int      sh;
        logic    vis;
        // Sample pitch as a shift, whole pixel down to an eighth
        case (subsample)
            SS_4X:   sh = RADIX - 1;
            SS_16X:  sh = RADIX - 2;
            SS_64X:  sh = RADIX - 3;
            default: sh = RADIX;
        endcase
        vis = 1'b1;
        for (int a = 0; a < 2; a++) begin
            for (int v = 0; v < VERTS; v++) begin
                pt[a][v] = tri_in[v][a];
            end
            lo[a] = pt[a][0];
            hi[a] = pt[a][0];
            for (int v = 1; v < VERTS; v++) begin
                lo[a] = (pt[a][v] < lo[a]) ? pt[a][v] : lo[a];
                hi[a] = (pt[a][v] > hi[a]) ? pt[a][v] : hi[a];
            end
            // Overlap is judged on the box before rounding
            if (lo[a] > screen[a] || hi[a] < 0) begin
                vis = 1'b0;
            end
            // Floor toward minus infinity, then clamp
            lo[a] = (lo[a] >>> sh) <<< sh;
            hi[a] = (hi[a] >>> sh) <<< sh;
            lo[a] = (lo[a] < 0) ? 0 : lo[a];
            hi[a] = (hi[a] > screen[a]) ? longint'(screen[a]) : hi[a];
        end
        // Culled winding when (x1-x0)(y2-y1) beats (x2-x1)(y1-y0)
        lhs = (pt[0][1] - pt[0][0]) * (pt[1][2] - pt[1][1]);
        rhs = (pt[0][2] - pt[0][1]) * (pt[1][1] - pt[1][0]);
        e.ll_x  = lo[0];
        e.ll_y  = lo[1];
        e.ur_x  = hi[0];
        e.ur_y  = hi[1];
        e.valid = valid_in && !(lhs > rhs) && vis;
        // Triangle and colors ride through untouched
        for (int v = 0; v < VERTS; v++) begin
            for (int a = 0; a < AXES; a++) begin
                e.tri_v[v][a] = tri_in[v][a];
            end
        end
        for (int c = 0; c < COLORS; c++) begin
            e.color[c] = color_in[c];
        end
        return e;
    endfunction

    task automatic check(input string name, input longint exp_val, input longint act_val);
        checks++;
        assert (exp_val == act_val) else begin
            $display("[FAIL] %0t ns %s expected %0d actual %0d", $time, name, exp_val, act_val);
            errors++;
        end
    endtask

    task automatic compare_front(input expect_t e);
        check("valid_out", e.valid, valid_out);
        check("box_out ll x", e.ll_x, box_out[CORNER_LL][AXIS_X]);
        check("box_out ll y", e.ll_y, box_out[CORNER_LL][AXIS_Y]);
        check("box_out ur x", e.ur_x, box_out[CORNER_UR][AXIS_X]);
        check("box_out ur y", e.ur_y, box_out[CORNER_UR][AXIS_Y]);
        for (int v = 0; v < VERTS; v++) begin
            for (int a = 0; a < AXES; a++) begin
                check($sformatf("tri_out %0d %0d", v, a), $signed(e.tri_v[v][a]),
                      tri_out[v][a]);
            end
        end
        // Colors carry a serial number, so order and loss show up here
        for (int c = 0; c < COLORS; c++) begin
            check($sformatf("color_out %0d", c), e.color[c], color_out[c]);
        end
    endtask

    // One falling edge: account for the rising edge just gone, then drive the next input
    task automatic step(input logic v, input logic h);
        @(negedge clk);
        if (!halt) begin
            exp_q.push_back(model_box());
        end
        if (exp_q.size() == PIPE_DEPTH) begin
            compare_front(exp_q.pop_front());
        end
        tri_in    = tri_next;
        subsample = sub_next;
        serial++;
        for (int c = 0; c < COLORS; c++) begin
            color_in[c] = SIGFIG'(serial * (c + 1));
        end
        valid_in = v;
        halt     = h;
    endtask

    task automatic flush();
        repeat (PIPE_DEPTH + 1) step(1'b0, 1'b0);
    endtask

    task automatic place(input int v, input longint x, input longint y);
        tri_next[v][AXIS_X] = x;
        tri_next[v][AXIS_Y] = y;
        tri_next[v][2]      = x + y;
    endtask

    // Front-facing triangle, flip swaps two vertices to reverse the winding
    task automatic load_tri(input longint off_x, input logic flip);
        place(0, fixed(100, 'h133) + off_x, fixed(100, 'h2d7));
        place(flip ? 2 : 1, fixed(150, 'h3ff) + off_x, fixed(300, 'h0f1));
        place(flip ? 1 : 2, fixed(200, 'h2ab) + off_x, fixed(120, 'h155));
    endtask

    task automatic report(input string name, input int mark);
        $display("Test %s finished with %0d errors", name, errors - mark);
    endtask

    initial begin
        int   mark;
        int   accepted;
        logic hold;
        seed     = 77;
        rst_n    = 1'b0;
        // A visible strobe during reset must not reach valid_out
        valid_in = 1'b1;
        halt     = 1'b0;
        subsample = SS_1X;
        sub_next  = SS_1X;
        screen[AXIS_X] = fixed(1024, 0);
        screen[AXIS_Y] = fixed(768, 0);
        for (int v = 0; v < VERTS; v++) begin
            for (int a = 0; a < AXES; a++) begin
                tri_in[v][a]   = '0;
                tri_next[v][a] = '0;
            end
        end
        for (int c = 0; c < COLORS; c++) begin
            color_in[c] = '0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n    = 1'b1;
        valid_in = 1'b0;

        // Same triangle snapped at every sample grid
        mark = errors;
        for (int k = 0; k < 4; k++) begin
            sub_next = subsample_e'(4'b1000 >> k);
            load_tri(0, 1'b0);
            step(1'b1, 1'b0);
            flush();
        end
        report("box and grid", mark);

        // Spans the origin and both far edges
        mark = errors;
        place(0, fixed(-20, 5), fixed(-10, 7));
        place(1, fixed(500, 0), fixed(800, 3));
        place(2, fixed(1100, 9), fixed(100, 0));
        step(1'b1, 1'b0);
        flush();
        report("clamping", mark);

        // Back face, wholly right of the screen, then no strobe
        mark = errors;
        load_tri(0, 1'b1);
        step(1'b1, 1'b0);
        load_tri(fixed(1200, 0), 1'b0);
        step(1'b1, 1'b0);
        load_tri(0, 1'b0);
        step(1'b0, 1'b0);
        flush();
        report("rejection", mark);

        // Fill the chain, freeze it, then drain
        mark = errors;
        for (int i = 0; i < 4; i++) begin
            load_tri(fixed(i * 10, 0), 1'b0);
            step(1'b1, 1'b0);
        end
        load_tri(fixed(400, 0), 1'b0);
        repeat (5) step(1'b1, 1'b1);
        flush();
        report("halt hold", mark);

        // Random triangles, grids and halts
        mark     = errors;
        accepted = 0;
        while (accepted < 200) begin
            hold = ($random(seed) & 3) == 0;
            for (int v = 0; v < VERTS; v++) begin
                place(v, rand_coord(), rand_coord());
            end
            sub_next = subsample_e'(4'b1000 >> ($random(seed) & 3));
            step(1'b1, hold);
            accepted += hold ? 0 : 1;
        end
        flush();
        report("random stream", mark);

        $display("Checks %0d, value errors %0d, assertion failures %0d",
                 checks, errors, bbox_top_i.bbox_assert_i.fails);
        errors += bbox_top_i.bbox_assert_i.fails;
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
